//--- dv/tb_soc.sv
// Testbench for the bus fabric top level.
// Acts as the bus master and checks the device table, scratch RAM,
// invalid slot, interrupts, warm reset and power-off against a model.
// Built from project.f with tb_soc as the top module.

`default_nettype none

`include "soc_cfg.svh"

module tb_soc
	import soc_pkg::*;
();

	localparam int WIN = `SOC_WINDOW_WORDS_LOG2;
	localparam int NSRC = `SOC_INT_SRC_COUNT;
	localparam int RAM_WORDS = 1 << `SOC_RAM_WORDS_LOG2;
	localparam int TIMEOUT = 20;
	localparam waddr_t DEVTBL_BASE = waddr_t'(`SOC_SLOT_DEVTBL) << WIN;
	localparam waddr_t INTC_BASE = waddr_t'(`SOC_SLOT_INTCTRL) << WIN;
	localparam waddr_t RAM_BASE = waddr_t'(`SOC_SLOT_RAM) << WIN;
	localparam waddr_t INVALID_BASE = waddr_t'(`SOC_SLOT_INVALID) << WIN;

	logic clk120mhz;
	logic rst_p;
	pi1_req_t master_req;
	pi1_rsp_t master_rsp;
	logic [NSRC-1:0] intr_src;
	logic intr_ack;
	logic intr_req;
	logic soc_ready;
	logic poweroff;

	// reference model state
	word_t ram_model [RAM_WORDS];
	logic [NSRC-1:0] en_model;
	logic [NSRC-1:0] pend_model;
	logic poweroff_model;
	int err_cnt;
	int tests_run;
	int tests_failed;
	int test_base;

	soc_fabric dut (
		.clk120mhz (clk120mhz),
		.rst_p (rst_p),
		.master_req_i (master_req),
		.master_rsp_o (master_rsp),
		.intr_src_i (intr_src),
		.intr_ack_i (intr_ack),
		.intr_req_o (intr_req),
		.soc_ready_o (soc_ready),
		.poweroff_o (poweroff)
	);

	always #2 clk120mhz = ~clk120mhz;

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		err_cnt++;
		$display("Error: %s got %h expected %h", name, got, exp);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt != test_base) begin
			tests_failed++;
			$display("test %s: failed, %0d errors", name, err_cnt - test_base);
		end else begin
			$display("test %s: ok", name);
		end
		test_base = err_cnt;
	endtask

	// invalid slot answers in the request cycle, every other slot one cycle later
	task automatic bus_xfer(input pi1_op_e op, input waddr_t addr, input word_t data,
			input bsel_t sel, output word_t rdata);
		int waited;
		int exp_lat;
		waited = 0;
		rdata = '0;
		exp_lat = (addr >= INVALID_BASE) ? 0 : 1;
		@(posedge clk120mhz);
		master_req <= '{op: op, addr: addr, data: data, sel: sel};
		@(negedge clk120mhz);
		while (!master_rsp.rdy && waited < TIMEOUT) begin
			waited++;
			@(negedge clk120mhz);
		end
		if (!master_rsp.rdy) begin
			err_cnt++;
			$display("timeout waiting for rdy at address %h", addr);
		end else begin
			rdata = master_rsp.data;
			if (waited != exp_lat)
				report_mismatch("master_rsp_o.rdy latency", word_t'(waited), word_t'(exp_lat));
		end
		@(posedge clk120mhz);
		master_req <= '{op: PI1_NOP, addr: '0, data: '0, sel: '0};
	endtask

	task automatic bus_write(input waddr_t addr, input word_t data, input bsel_t sel);
		word_t unused;
		bus_xfer(PI1_WR, addr, data, sel, unused);
	endtask

	task automatic bus_read(input waddr_t addr, output word_t rdata);
		bus_xfer(PI1_RD, addr, '0, '1, rdata);
	endtask

	task automatic bus_swap(input waddr_t addr, input word_t data, output word_t rdata);
		bus_xfer(PI1_RW, addr, data, '1, rdata);
	endtask

	// want_ready picks soc_ready_o, otherwise poweroff_o
	task automatic wait_status(input bit want_ready, input logic level, input int limit);
		int n;
		logic v;
		n = 0;
		@(negedge clk120mhz);
		v = want_ready ? soc_ready : poweroff;
		while (v !== level && n < limit) begin
			n++;
			@(negedge clk120mhz);
			v = want_ready ? soc_ready : poweroff;
		end
		if (v !== level) begin
			err_cnt++;
			$display("timeout: %s did not go to %0d within %0d cycles",
				want_ready ? "soc_ready_o" : "poweroff_o", level, limit);
		end
	endtask

	function automatic word_t expected_id(input int slot);
		case (slot)
			`SOC_SLOT_DEVTBL: return `SOC_ID_DEVTBL;
			`SOC_SLOT_INTCTRL: return `SOC_ID_INTCTRL;
			`SOC_SLOT_RAM: return `SOC_ID_RAM;
			default: return `SOC_ID_INVALID;
		endcase
	endfunction

	// lowest-numbered pending and enabled source or -1 when none
	function automatic int lowest_active();
		for (int i = 0; i < NSRC; i++) begin
			if (pend_model[i] && en_model[i])
				return i;
		end
		return -1;
	endfunction

	task automatic pulse_sources(input logic [NSRC-1:0] v);
		@(posedge clk120mhz);
		intr_src <= v;
		@(posedge clk120mhz);
		intr_src <= '0;
		pend_model = pend_model | v;
	endtask

	task automatic pulse_ack();
		int i;
		@(posedge clk120mhz);
		intr_ack <= 1'b1;
		@(posedge clk120mhz);
		intr_ack <= 1'b0;
		i = lowest_active();
		if (i >= 0)
			pend_model[i] = 1'b0;
	endtask

	task automatic check_claim();
		word_t rd;
		word_t exp;
		int i;
		i = lowest_active();
		exp = '0;
		if (i >= 0) begin
			exp = 32'h8000_0000 | word_t'(i);
			pend_model[i] = 1'b0;
		end
		bus_read(INTC_BASE, rd);
		if (rd !== exp)
			report_mismatch("master_rsp_o.data claim", rd, exp);
	endtask

	task automatic check_intr();
		logic exp;
		exp = |(pend_model & en_model);
		@(negedge clk120mhz);
		if (intr_req !== exp)
			report_mismatch("intr_req_o", word_t'(intr_req), word_t'(exp));
	endtask

	task automatic check_ram(input int idx);
		word_t rd;
		bus_read(RAM_BASE + waddr_t'(idx), rd);
		if (rd !== ram_model[idx])
			report_mismatch("master_rsp_o.data", rd, ram_model[idx]);
	endtask

	initial begin
		word_t rd;
		word_t wdata;
		waddr_t a;
		bsel_t sel;
		int idx;
		int op;
		clk120mhz = 1'b0;
		rst_p = 1'b1;
		master_req = '{op: PI1_NOP, addr: '0, data: '0, sel: '0};
		intr_src = '0;
		intr_ack = 1'b0;
		en_model = '0;
		pend_model = '0;
		poweroff_model = 1'b0;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		test_base = 0;
		void'($urandom(83939));

		repeat (4) @(posedge clk120mhz);
		rst_p <= 1'b0;
		wait_status(1'b1, 1'b1, 40);

		// device table contents
		for (int i = 0; i < 4; i++) begin
			bus_read(DEVTBL_BASE + waddr_t'(i), rd);
			if (rd !== expected_id(i))
				report_mismatch("master_rsp_o.data device id", rd, expected_id(i));
			bus_read(DEVTBL_BASE + waddr_t'(8 + i), rd);
			if (rd !== 32'd4096)
				report_mismatch("master_rsp_o.data map size", rd, 32'd4096);
		end
		bus_read(DEVTBL_BASE + 16, rd);
		if (rd !== 32'd4)
			report_mismatch("master_rsp_o.data slot count", rd, 32'd4);
		bus_read(DEVTBL_BASE + 5, rd);
		if (rd !== '0)
			report_mismatch("master_rsp_o.data unmapped offset", rd, '0);
		finish_test("device table");

		// give every RAM word a known value before the random accesses
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_model[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h3c};
			bus_write(RAM_BASE + waddr_t'(i), ram_model[i], '1);
		end
		for (int n = 0; n < 200; n++) begin
			a = RAM_BASE + waddr_t'($urandom_range(0, 1023));
			idx = int'(a[`SOC_RAM_WORDS_LOG2-1:0]);
			op = $urandom_range(0, 2);
			wdata = $urandom;
			if (op == 0) begin
				sel = bsel_t'($urandom_range(0, 15));
				bus_write(a, wdata, sel);
				for (int b = 0; b < 4; b++) begin
					if (sel[b])
						ram_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
				end
			end else if (op == 1) begin
				bus_read(a, rd);
				if (rd !== ram_model[idx])
					report_mismatch("master_rsp_o.data", rd, ram_model[idx]);
			end else begin
				bus_swap(a, wdata, rd);
				if (rd !== ram_model[idx])
					report_mismatch("master_rsp_o.data swap old word", rd, ram_model[idx]);
				ram_model[idx] = wdata;
			end
		end
		finish_test("scratch ram");

		// the invalid slot covers the slot 3 window and the space above it
		for (int n = 0; n < 20; n++) begin
			a = waddr_t'($urandom);
			if (n % 2 == 0)
				a = INVALID_BASE + waddr_t'($urandom_range(0, 1023));
			else if (a < INVALID_BASE)
				a = a + INVALID_BASE;
			bus_read(a, rd);
			if (rd !== '0)
				report_mismatch("master_rsp_o.data invalid slot", rd, '0);
			bus_write(a, $urandom, '1);
		end
		for (int i = 0; i < RAM_WORDS; i++)
			check_ram(i);
		finish_test("invalid slot");

		// interrupts
		for (int n = 0; n < 16; n++) begin
			wdata = $urandom;
			bus_write(INTC_BASE + 1, wdata, '1);
			en_model = wdata[NSRC-1:0];
			bus_read(INTC_BASE + 1, rd);
			if (rd !== word_t'(en_model))
				report_mismatch("master_rsp_o.data enable mask", rd, word_t'(en_model));
			pulse_sources(NSRC'($urandom_range(0, (1 << NSRC) - 1)));
			check_intr();
			bus_read(INTC_BASE + 2, rd);
			if (rd !== word_t'(pend_model))
				report_mismatch("master_rsp_o.data pending", rd, word_t'(pend_model));
			if ($urandom_range(0, 1) == 0)
				check_claim();
			else
				pulse_ack();
			check_intr();
		end
		// drain everything so that the last claim reads zero
		bus_write(INTC_BASE + 1, '1, '1);
		en_model = '1;
		for (int n = 0; n <= NSRC; n++)
			check_claim();
		check_intr();
		finish_test("interrupts");

		// leave something pending so that the warm reset is seen clearing it
		pulse_sources('1);
		bus_write(DEVTBL_BASE + 24, 32'd2, '1);
		wait_status(1'b1, 1'b0, 4);
		wait_status(1'b1, 1'b1, 40);
		en_model = '0;
		pend_model = '0;
		bus_read(INTC_BASE + 1, rd);
		if (rd !== '0)
			report_mismatch("master_rsp_o.data enable mask", rd, '0);
		bus_read(INTC_BASE + 2, rd);
		if (rd !== '0)
			report_mismatch("master_rsp_o.data pending", rd, '0);
		check_intr();
		for (int i = 0; i < RAM_WORDS; i++)
			check_ram(i);
		finish_test("warm reset");

		// power-off holds until the board reset
		bus_write(DEVTBL_BASE + 24, 32'd1, '1);
		poweroff_model = 1'b1;
		wait_status(1'b0, 1'b1, 4);
		for (int n = 0; n < 50; n++) begin
			@(negedge clk120mhz);
			if (poweroff !== poweroff_model)
				report_mismatch("poweroff_o", word_t'(poweroff), word_t'(poweroff_model));
			if (soc_ready !== 1'b0)
				report_mismatch("soc_ready_o", word_t'(soc_ready), '0);
		end
		@(posedge clk120mhz);
		rst_p <= 1'b1;
		repeat (4) @(posedge clk120mhz);
		rst_p <= 1'b0;
		poweroff_model = 1'b0;
		wait_status(1'b1, 1'b1, 40);
		if (poweroff !== poweroff_model)
			report_mismatch("poweroff_o", word_t'(poweroff), word_t'(poweroff_model));
		finish_test("power-off");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/dev_table.sv
// Device table slave.
// Software reads it to learn each slot's device ID and map size and the
// slot count. Offset 24 is the reset-control register; writing 2 asks for
// a warm reset and writing 1 asks for power-off, each as a one-cycle pulse
// in the cycle after the write's rdy. Values 0 and 3 are ignored.

`default_nettype none

`include "soc_cfg.svh"

module dev_table
	import soc_pkg::*;
(
	input wire logic clk120mhz,
	input wire logic rst_i,
	input wire pi1_req_t req_i,
	output pi1_rsp_t rsp_o,
	output logic warm_rst_req_o,
	output logic pwroff_req_o
);

	localparam int SLOT_COUNT = 1 << `SOC_SLOT_BITS;
	localparam int MAPSZ_BYTES = (1 << `SOC_WINDOW_WORDS_LOG2) * (`SOC_ARCH_BITS / 8);
	localparam int OFF_MAPSZ = 8;
	localparam int OFF_COUNT = 16;
	localparam int OFF_RSTCTRL = 24;

	logic [`SOC_WINDOW_WORDS_LOG2-1:0] offset;
	logic accept;
	logic rdy_q;
	logic [1:0] ctrl_q;
	logic warm_q;
	logic pwroff_q;
	word_t rd_word;
	word_t rd_q;

	function automatic word_t slot_id(input slot_t s);
		word_t id;
		case (s)
			`SOC_SLOT_DEVTBL: id = `SOC_ID_DEVTBL;
			`SOC_SLOT_INTCTRL: id = `SOC_ID_INTCTRL;
			`SOC_SLOT_RAM: id = `SOC_ID_RAM;
			`SOC_SLOT_INVALID: id = `SOC_ID_INVALID;
			default: id = '0;
		endcase
		return id;
	endfunction

	assign offset = req_i.addr[`SOC_WINDOW_WORDS_LOG2-1:0];
	// a held request is not served again while rdy is up
	assign accept = (req_i.op != PI1_NOP) && !rdy_q;

	always_comb begin
		rd_word = '0;
		if (offset < SLOT_COUNT)
			rd_word = slot_id(slot_t'(offset));
		else if (offset >= OFF_MAPSZ && offset < OFF_MAPSZ + SLOT_COUNT)
			rd_word = word_t'(MAPSZ_BYTES);
		else if (offset == OFF_COUNT)
			rd_word = word_t'(SLOT_COUNT);
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
			ctrl_q <= 2'b00;
			warm_q <= 1'b0;
			pwroff_q <= 1'b0;
		end else begin
			rdy_q <= accept;
			// ctrl_q is non-zero only in the rdy cycle of a control write
			ctrl_q <= (accept && req_i.op == PI1_WR && offset == OFF_RSTCTRL) ?
				req_i.data[1:0] : 2'b00;
			warm_q <= (ctrl_q == 2'b10);
			pwroff_q <= (ctrl_q == 2'b01);
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (accept)
			rd_q <= rd_word;
	end

	assign rsp_o = '{data: rd_q, rdy: rdy_q};
	assign warm_rst_req_o = warm_q;
	assign pwroff_req_o = pwroff_q;

endmodule

`default_nettype wire

//--- logic/int_ctrl.sv
// Interrupt controller with edge-latched sources and one destination.
// A rising edge on a source sets its pending bit; intr_req_o is high while
// any pending source is enabled. An intr_ack_i pulse or a claim read clears
// the lowest-numbered pending enabled source.
// Offsets: 0 claim (read), 1 enable mask (read/write), 2 raw pending (read).

`default_nettype none

`include "soc_cfg.svh"

module int_ctrl
	import soc_pkg::*;
(
	input wire logic clk120mhz,
	input wire logic rst_i,
	input wire pi1_req_t req_i,
	output pi1_rsp_t rsp_o,
	input wire logic [`SOC_INT_SRC_COUNT-1:0] intr_src_i,
	input wire logic intr_ack_i,
	output logic intr_req_o
);

	localparam int IDX_BITS = (`SOC_INT_SRC_COUNT > 1) ? $clog2(`SOC_INT_SRC_COUNT) : 1;

	typedef logic [`SOC_INT_SRC_COUNT-1:0] src_vec_t;

	src_vec_t src_q, pending_q, enable_q, active, clear_vec;
	logic [IDX_BITS-1:0] best_idx;
	logic best_vld;
	logic [`SOC_WINDOW_WORDS_LOG2-1:0] offset;
	logic accept, is_write, claim_clr;
	logic rdy_q;
	word_t rd_word, rd_q;

	assign offset = req_i.addr[`SOC_WINDOW_WORDS_LOG2-1:0];
	assign accept = (req_i.op != PI1_NOP) && !rdy_q;
	assign is_write = (req_i.op == PI1_WR);
	assign active = pending_q & enable_q;

	// lowest-numbered active source wins
	always_comb begin
		best_idx = '0;
		best_vld = 1'b0;
		for (int i = `SOC_INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (active[i]) begin
				best_idx = IDX_BITS'(i);
				best_vld = 1'b1;
			end
		end
	end

	assign claim_clr = accept && !is_write && offset == 0 && best_vld;
	assign clear_vec = ((claim_clr || intr_ack_i) && best_vld) ? src_vec_t'(1) << best_idx : '0;

	always_comb begin
		rd_word = '0;
		if (offset == 0 && best_vld)
			rd_word = word_t'(best_idx) | (word_t'(1) << (`SOC_ARCH_BITS - 1));
		else if (offset == 1)
			rd_word = word_t'(enable_q);
		else if (offset == 2)
			rd_word = word_t'(pending_q);
	end

	// previous source levels for edge detection
	always_ff @(posedge clk120mhz)
		src_q <= intr_src_i;

	always_ff @(posedge clk120mhz) begin
		if (rst_i) begin
			rdy_q <= 1'b0;
			pending_q <= '0;
			enable_q <= '0;
		end else begin
			rdy_q <= accept;
			pending_q <= (pending_q & ~clear_vec) | (intr_src_i & ~src_q);
			if (accept && is_write && offset == 1 && req_i.sel[0])
				enable_q <= req_i.data[`SOC_INT_SRC_COUNT-1:0];
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (accept)
			rd_q <= rd_word;
	end

	assign rsp_o = '{data: rd_q, rdy: rdy_q};
	assign intr_req_o = |active;

	assert property (@(posedge clk120mhz) disable iff (rst_i) rsp_o.rdy |=> !rsp_o.rdy)
		else $error("int_ctrl rdy high two cycles in a row");

endmodule

`default_nettype wire

//--- logic/pi1_router.sv
// Single-master router for the peripheral bus.
// Decodes the word address into fixed 4 KB windows, steers the request to
// the selected slave with every other slave seeing NOP, and returns only
// the selected slave's response. The invalid-device slot lives here and
// answers at once with zero data; addresses past the last slot land there.

`default_nettype none

`include "soc_cfg.svh"

module pi1_router
	import soc_pkg::*;
(
	input wire logic clk120mhz,
	input wire logic rst_i,
	input wire pi1_req_t master_req_i,
	output pi1_rsp_t master_rsp_o,
	output pi1_req_t devtbl_req_o,
	input wire pi1_rsp_t devtbl_rsp_i,
	output pi1_req_t intctrl_req_o,
	input wire pi1_rsp_t intctrl_rsp_i,
	output pi1_req_t ram_req_o,
	input wire pi1_rsp_t ram_rsp_i
);

	localparam int SLOT_LSB = `SOC_WINDOW_WORDS_LOG2;
	localparam int UPPER_LSB = `SOC_WINDOW_WORDS_LOG2 + `SOC_SLOT_BITS;

	slot_t slot;
	logic upper_hit;
	pi1_rsp_t invalid_rsp;

	// only the addressed slave gets the real op
	function automatic pi1_req_t steer(input pi1_req_t req, input logic hit);
		pi1_req_t out;
		out = req;
		if (!hit)
			out.op = PI1_NOP;
		return out;
	endfunction

	// anything above the slot field falls into the invalid slot
	assign upper_hit = |master_req_i.addr[`SOC_ADDR_BITS-1:UPPER_LSB];
	assign slot = upper_hit ? slot_t'(`SOC_SLOT_INVALID) :
		master_req_i.addr[SLOT_LSB +: `SOC_SLOT_BITS];

	assign devtbl_req_o = steer(master_req_i, slot == slot_t'(`SOC_SLOT_DEVTBL));
	assign intctrl_req_o = steer(master_req_i, slot == slot_t'(`SOC_SLOT_INTCTRL));
	assign ram_req_o = steer(master_req_i, slot == slot_t'(`SOC_SLOT_RAM));

	// invalid slot completes in the same cycle
	assign invalid_rsp = '{data: '0, rdy: (master_req_i.op != PI1_NOP)};

	always_comb begin
		case (slot)
			slot_t'(`SOC_SLOT_DEVTBL): master_rsp_o = devtbl_rsp_i;
			slot_t'(`SOC_SLOT_INTCTRL): master_rsp_o = intctrl_rsp_i;
			slot_t'(`SOC_SLOT_RAM): master_rsp_o = ram_rsp_i;
			default: master_rsp_o = invalid_rsp;
		endcase
	end

	// a slave answers only while its own window is still addressed
	assert property (@(posedge clk120mhz) disable iff (rst_i)
		(!devtbl_rsp_i.rdy || slot == slot_t'(`SOC_SLOT_DEVTBL)) &&
		(!intctrl_rsp_i.rdy || slot == slot_t'(`SOC_SLOT_INTCTRL)) &&
		(!ram_rsp_i.rdy || slot == slot_t'(`SOC_SLOT_RAM)))
		else $error("unselected slave raised rdy, slot %0d", slot);

endmodule

`default_nettype wire

//--- logic/reset_seq.sv
// System reset sequencer.
// A board reset or a warm-reset request reloads a down-counter, and the
// system stays in reset until it reaches zero. A power-off request sets a
// latch that holds the system in reset until the next board reset.

`default_nettype none

`include "soc_cfg.svh"

module reset_seq (
	input wire logic clk120mhz,
	input wire logic rst_p,
	input wire logic warm_rst_req_i,
	input wire logic pwroff_req_i,
	output logic soc_rst_o,
	output logic poweroff_o
);

	logic [`SOC_RST_CNT_BITS-1:0] cnt_q;
	logic poweroff_q;

	always_ff @(posedge clk120mhz) begin
		if (rst_p || warm_rst_req_i)
			cnt_q <= '1;
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
	end

	// only the board reset clears power-off
	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			poweroff_q <= 1'b0;
		else if (pwroff_req_i)
			poweroff_q <= 1'b1;
	end

	assign soc_rst_o = (cnt_q != '0) || poweroff_q;
	assign poweroff_o = poweroff_q;

	assert property (@(posedge clk120mhz) (poweroff_o && !rst_p) |=> poweroff_o)
		else $error("poweroff_o fell without rst_p");

endmodule

`default_nettype wire

//--- logic/scratch_ram.sv
// Scratch RAM slave, 256 words with byte-select writes, reads and swap.
// Tie rst_i to the board reset so that the contents and the bus state are
// kept across a warm reset. The array itself is never cleared.

`default_nettype none

`include "soc_cfg.svh"

module scratch_ram
	import soc_pkg::*;
(
	input wire logic clk120mhz,
	input wire logic rst_i,
	input wire pi1_req_t req_i,
	output pi1_rsp_t rsp_o
);

	localparam int DEPTH = 1 << `SOC_RAM_WORDS_LOG2;
	localparam int BYTES = `SOC_ARCH_BITS / 8;

	word_t mem [DEPTH];
	logic [`SOC_RAM_WORDS_LOG2-1:0] idx;
	logic accept;
	logic rdy_q;
	word_t rd_q;

	assign idx = req_i.addr[`SOC_RAM_WORDS_LOG2-1:0];
	assign accept = (req_i.op != PI1_NOP) && !rdy_q;

	always_ff @(posedge clk120mhz) begin
		if (rst_i)
			rdy_q <= 1'b0;
		else
			rdy_q <= accept;
	end

	// old word is read out before a swap overwrites it
	always_ff @(posedge clk120mhz) begin
		if (accept) begin
			rd_q <= mem[idx];
			if (req_i.op == PI1_WR || req_i.op == PI1_RW) begin
				for (int b = 0; b < BYTES; b++) begin
					if (req_i.sel[b])
						mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
				end
			end
		end
	end

	assign rsp_o = '{data: rd_q, rdy: rdy_q};

endmodule

`default_nettype wire

//--- logic/soc_cfg.svh
// Configuration macros for the bus fabric and the system-control devices.
// Include this header wherever a width, slot index, device ID or count is
// needed. The package that holds the shared types includes it as well.

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// one data word and a word address
`define SOC_ARCH_BITS 32
`define SOC_ADDR_BITS 30

// slot select sits just above the 4 KB window
`define SOC_SLOT_BITS 2
`define SOC_WINDOW_WORDS_LOG2 10

// slot indices as seen by the router
`define SOC_SLOT_DEVTBL 0
`define SOC_SLOT_INTCTRL 1
`define SOC_SLOT_RAM 2
`define SOC_SLOT_INVALID 3

// device IDs reported by the device table
`define SOC_ID_DEVTBL 7
`define SOC_ID_INTCTRL 3
`define SOC_ID_RAM 1
`define SOC_ID_INVALID 0

// interrupt controller and scratch RAM sizing
`define SOC_INT_SRC_COUNT 2
`define SOC_RAM_WORDS_LOG2 8

// all ones is loaded into the reset counter on a reset request
`define SOC_RST_CNT_BITS 4

`endif

//--- logic/soc_fabric.sv
// Top level of the bus fabric and system-control devices.
// An external master drives master_req_i and waits for rdy on master_rsp_o.
// The router splits the address space into 4 KB slots for the device table,
// the interrupt controller, the scratch RAM and the invalid device.
// soc_ready_o is high once the reset sequence has finished.

`default_nettype none

`include "soc_cfg.svh"

module soc_fabric
	import soc_pkg::*;
(
	input wire logic clk120mhz,
	input wire logic rst_p,
	input wire pi1_req_t master_req_i,
	output pi1_rsp_t master_rsp_o,
	input wire logic [`SOC_INT_SRC_COUNT-1:0] intr_src_i,
	input wire logic intr_ack_i,
	output logic intr_req_o,
	output logic soc_ready_o,
	output logic poweroff_o
);

	logic soc_rst;
	logic warm_rst_req;
	logic pwroff_req;

	pi1_req_t devtbl_req, intctrl_req, ram_req;
	pi1_rsp_t devtbl_rsp, intctrl_rsp, ram_rsp;

	reset_seq u_reset_seq (
		.clk120mhz (clk120mhz),
		.rst_p (rst_p),
		.warm_rst_req_i (warm_rst_req),
		.pwroff_req_i (pwroff_req),
		.soc_rst_o (soc_rst),
		.poweroff_o (poweroff_o)
	);

	assign soc_ready_o = !soc_rst;

	pi1_router u_router (
		.clk120mhz (clk120mhz),
		.rst_i (soc_rst),
		.master_req_i (master_req_i),
		.master_rsp_o (master_rsp_o),
		.devtbl_req_o (devtbl_req),
		.devtbl_rsp_i (devtbl_rsp),
		.intctrl_req_o (intctrl_req),
		.intctrl_rsp_i (intctrl_rsp),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp)
	);

	dev_table u_dev_table (
		.clk120mhz (clk120mhz),
		.rst_i (soc_rst),
		.req_i (devtbl_req),
		.rsp_o (devtbl_rsp),
		.warm_rst_req_o (warm_rst_req),
		.pwroff_req_o (pwroff_req)
	);

	int_ctrl u_int_ctrl (
		.clk120mhz (clk120mhz),
		.rst_i (soc_rst),
		.req_i (intctrl_req),
		.rsp_o (intctrl_rsp),
		.intr_src_i (intr_src_i),
		.intr_ack_i (intr_ack_i),
		.intr_req_o (intr_req_o)
	);

	// reset by the board reset only so that its contents survive a warm reset
	scratch_ram u_scratch_ram (
		.clk120mhz (clk120mhz),
		.rst_i (rst_p),
		.req_i (ram_req),
		.rsp_o (ram_rsp)
	);

endmodule

`default_nettype wire

//--- logic/soc_pkg.sv
// Shared types for the peripheral bus.
// Holds the word, address, byte-select and slot vector types, the bus
// operation encoding and the request/response structs that travel between
// the master, the router and every slave. Import with soc_pkg::*.

`default_nettype none

`include "soc_cfg.svh"

package soc_pkg;

	typedef logic [`SOC_ARCH_BITS-1:0] word_t;
	typedef logic [`SOC_ADDR_BITS-1:0] waddr_t;
	typedef logic [`SOC_ARCH_BITS/8-1:0] bsel_t;
	typedef logic [`SOC_SLOT_BITS-1:0] slot_t;

	// RW returns the old word and writes the new one
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR = 2'b01,
		PI1_RD = 2'b10,
		PI1_RW = 2'b11
	} pi1_op_e;

	// held stable by the master until rdy is seen
	typedef struct packed {
		pi1_op_e op;
		waddr_t addr;
		word_t data;
		bsel_t sel;
	} pi1_req_t;

	// rdy is high for one cycle per request
	typedef struct packed {
		word_t data;
		logic rdy;
	} pi1_rsp_t;

endpackage

`default_nettype wire

//--- project.f
+incdir+logic
logic/soc_pkg.sv
logic/reset_seq.sv
logic/pi1_router.sv
logic/dev_table.sv
logic/int_ctrl.sv
logic/scratch_ram.sv
logic/soc_fabric.sv
dv/tb_soc.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
# Exit status is non-zero if the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_soc \
	-Mdir obj_dir -o tb_soc > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status, see build.log"
	exit 1
fi

./obj_dir/tb_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
exit 0
